/* files.f */
+incdir+hdl
hdl/led_panel_pkg.sv
hdl/frame_memory.sv
hdl/row_scanner.sv
hdl/pad_poller.sv
hdl/led_panel_top.sv
verification/led_panel_sva.sv
verification/panel_checker.sv
verification/led_panel_tb.sv

/* Makefile */
# Verilator build and run of the LED panel testbench

sim:
	verilator --binary --timing --assert -Ihdl -f files.f --top-module led_panel_tb \
		-o sim_tb
	./obj_dir/sim_tb > sim.log 2>&1; cat sim.log
	@if grep -q ">>> FAIL" sim.log; then exit 1; fi
	@grep -q ">>> PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

/* verification/panel_testdata.hex */
# w <y> <x> <color>: pixel write, y and x in hex, other pixels are random
# r <reply bytes 4..0> <expected buttons {byte4, byte3}>: one pad poll
w 00 00 f
w 00 01 1
w 00 3f 7
w 1f 00 a
w 1f 3f 5
w 20 00 0
w 20 3f c
w 3f 00 3
w 3f 3f e
w 10 20 9
w 30 20 6
w 05 2a b
w 25 2a d
w 0c 11 2
w 2c 11 8
w 17 33 4
r a53c5a41ff a53c
r 7ec35a41ff 7ec3

/* verification/led_panel_tb.sv */
// --------------------------------------------------
// LED panel testbench
// --------------------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "led_panel_consts.svh"

// game pad reply source, lsb first
module pad_device (
	input  wire        spi_clk,
	input  wire        cs_n,
	input  wire [79:0] replies,
	output logic       miso
);

	int idx;
	int poll;

	initial begin
		idx = 0;
		poll = 0;
		miso = 1'b0;
	end

	always @(posedge spi_clk or posedge cs_n) begin
		if (cs_n === 1'b1) begin
			if (idx == 40) begin  // end of a full poll
				idx <= 0;
				poll <= poll + 1;
			end
		end else if (cs_n === 1'b0) begin
			idx <= idx + 1;
		end
	end

	always @(negedge spi_clk) begin
		if (cs_n === 1'b0)
			miso <= replies[poll*40 + idx];
	end

endmodule

module led_panel_tb
	import led_panel_pkg::*;
;

	localparam int frame_cycles = `SCAN_ROWS *
		(`PANEL_COLS * 4 + `LATCH_CYCLES + `OE_CYCLES + `ROW_GAP_CYCLES);
	localparam int poll_cycles = `SPI_IDLE_CYCLES +
		`SPI_BYTES * (16 * `SPI_HALF_CYCLES + `SPI_BYTE_GAP);
	localparam int limit = 2 * frame_cycles + 2 * poll_cycles + 4000;

	logic clk, rst, miso, display_clk, latch, display_oe, spi_clk, cs_n, mosi, done;
	pix_write_t pix_wr;
	row_t row_addr;
	col_t col_addr;
	color_t dout_a, dout_b;
	logic [15:0] pad_buttons;
	logic [79:0] replies;
	logic [31:0] exp_btns;
	int errors;
	int cycles;
	color_t img [4096];

	led_panel_top dut0 (.*);

	pad_device pad0 (.spi_clk(spi_clk), .cs_n(cs_n), .replies(replies), .miso(miso));

	panel_checker chk0 (.*);

	bind led_panel_top led_panel_sva sva0 (
		.clk(clk), .rst(rst), .latch(latch), .display_oe(display_oe),
		.spi_clk(spi_clk), .cs_n(cs_n), .mosi(mosi)
	);

	always #20 clk = ~clk;

	always @(posedge clk) cycles <= cycles + 1;

	initial begin
		int fd, n_reply, rc;
		string line;
		logic [7:0] tag;
		logic [39:0] a;
		logic [15:0] b;
		logic [3:0] c;
		logic file_ok;
		clk = 1'b0;
		rst = 1'b1;
		pix_wr = '0;
		replies = '0;
		exp_btns = '0;
		cycles = 0;
		n_reply = 0;
		void'($urandom(32'hcca8_bcdc));
		for (int i = 0; i < 4096; i++)
			img[i] = color_t'($urandom);
		fd = $fopen("verification/panel_testdata.hex", "r");
		file_ok = (fd != 0);
		if (!file_ok) begin
			$display("cannot open the test data file");
		end else begin
			while ($fgets(line, fd) > 0) begin
				rc = $sscanf(line, "%c %h %h %h", tag, a, b, c);
				if (tag == "w" && rc == 4)
					img[{a[5:0], b[5:0]}] = c;  // file pixel wins over random fill
				else if (tag == "r" && rc >= 3 && n_reply < 2) begin
					replies[n_reply*40 +: 40] = a;
					exp_btns[n_reply*16 +: 16] = b;
					n_reply++;
				end
			end
			$fclose(fd);
		end
		repeat (4) @(negedge clk);
		rst = 1'b0;
		for (int i = 0; i < 4096; i++) begin
			@(negedge clk);
			pix_wr = '{valid: 1'b1, y: i[11:6], x: i[5:0], color: img[i]};
		end
		@(negedge clk);
		pix_wr = '0;
		while (file_ok && !done && cycles < limit)
			@(negedge clk);
		if (file_ok && !done)
			$display("timeout after %0d cycles with tests unfinished", cycles);
		if (file_ok && done && errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* verification/panel_checker.sv */
// --------------------------------------------------
// Panel and pad pin checker
// --------------------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "led_panel_consts.svh"

module panel_checker
	import led_panel_pkg::*;
(
	input  wire              clk,
	input  wire              rst,
	input  wire pix_write_t  pix_wr,
	input  wire [31:0]       exp_btns,  // poll 1 upper, poll 0 lower
	input  wire row_t        row_addr,
	input  wire col_t        col_addr,
	input  wire              display_clk,
	input  wire              latch,
	input  wire              display_oe,
	input  wire color_t      dout_a,
	input  wire color_t      dout_b,
	input  wire              spi_clk,
	input  wire              cs_n,
	input  wire              mosi,
	input  wire [15:0]       pad_buttons,
	output logic             done,
	output int               errors
);

	localparam int row_period = `PANEL_COLS * 4 + `LATCH_CYCLES + `OE_CYCLES + `ROW_GAP_CYCLES;

	color_t model [4096];
	int n_pass, n_fail, err_pix, err_row, err_mosi, err_btn, err_rst;
	int frame_cnt, latch_run, oe_run, period_cnt, exp_row, exp_col, bit_n, byte_n, poll;
	logic prev_latch, prev_oe, prev_spi, prev_cs, seen_latch, in_reset, scan_done, rst_q;
	row_t prev_row;
	logic [7:0] rx_byte;

	function automatic logic [7:0] send_byte(input int k);
		return (k == 0) ? 8'h01 : (k == 1) ? 8'h42 : 8'h00;
	endfunction

	task automatic mismatch(input string name, input int exp_v, input int act_v, inout int cnt);
		$display("Fail %s: expected %0h, actual %0h", name, exp_v, act_v);
		cnt++;
		errors++;
	endtask

	task automatic finish_test(input string name, input int cnt);
		if (cnt == 0) begin
			$display("test %s: ok", name);
			n_pass++;
		end else begin
			$display("test %s: %0d errors", name, cnt);
			n_fail++;
		end
	endtask

	initial begin
		for (int i = 0; i < 4096; i++)
			model[i] = '0;
		{n_pass, n_fail, err_pix, err_row, err_mosi, err_btn, err_rst} = '0;
		{frame_cnt, latch_run, oe_run, period_cnt, exp_row, exp_col, bit_n, byte_n, poll} = '0;
		{prev_latch, seen_latch, scan_done, done} = '0;
		{prev_oe, prev_spi, prev_cs, in_reset, rst_q} = '1;
		prev_row = '0;
		rx_byte = '0;
		errors = 0;
	end

	// image model built from the host write port
	always @(posedge clk) begin
		rst_q <= rst;
		if (pix_wr.valid)
			model[{pix_wr.y, pix_wr.x}] <= pix_wr.color;
	end

	always @(negedge clk) begin
		if (rst_q || in_reset) begin
			if (display_oe !== 1'b1)
				mismatch("reset state display_oe", 1, display_oe, err_rst);
			if (latch !== 1'b0)
				mismatch("reset state latch", 0, latch, err_rst);
			if (cs_n !== 1'b1)
				mismatch("reset state cs_n", 1, cs_n, err_rst);
			if (pad_buttons !== '0)
				mismatch("reset state pad_buttons", 0, pad_buttons, err_rst);
			if (!rst_q) begin
				in_reset = 1'b0;  // first cycle after reset checked too
				finish_test("reset state", err_rst);
			end
		end else begin
			if (display_clk) begin
				if (col_addr !== col_t'(exp_col))
					mismatch("row sequencing column", exp_col, col_addr, err_row);
				exp_col = (exp_col + 1) % `PANEL_COLS;
				if (frame_cnt == 1) begin
					if (dout_a !== model[{1'b0, row_addr, col_addr}])
						mismatch("pixel shift-out top", model[{1'b0, row_addr, col_addr}],
							dout_a, err_pix);
					if (dout_b !== model[{1'b1, row_addr, col_addr}])
						mismatch("pixel shift-out bottom", model[{1'b1, row_addr, col_addr}],
							dout_b, err_pix);
				end
			end
			period_cnt++;
			if (latch && !prev_latch) begin
				if (row_addr !== row_t'(exp_row))
					mismatch("row sequencing row", exp_row, row_addr, err_row);
				if (seen_latch && period_cnt != row_period)
					mismatch("row sequencing period", row_period, period_cnt, err_row);
				if (exp_col != 0)
					mismatch("row sequencing columns before latch", 0, exp_col, err_row);
				exp_row = (exp_row + 1) % `SCAN_ROWS;
				period_cnt = 0;
				seen_latch = 1'b1;
			end
			if (latch)
				latch_run++;
			else if (prev_latch) begin
				if (latch_run != `LATCH_CYCLES)
					mismatch("row sequencing latch length", `LATCH_CYCLES, latch_run, err_row);
				latch_run = 0;
			end
			if (!display_oe)
				oe_run++;
			else if (!prev_oe) begin
				if (oe_run != `OE_CYCLES)
					mismatch("row sequencing oe window", `OE_CYCLES, oe_run, err_row);
				oe_run = 0;
			end
			if (prev_row == row_t'(`SCAN_ROWS - 1) && row_addr == '0) begin
				frame_cnt++;
				if (frame_cnt == 2) begin
					finish_test("pixel shift-out", err_pix);
					finish_test("row sequencing", err_row);
					scan_done = 1'b1;
				end
			end
			// serial side
			if (spi_clk && !prev_spi && !cs_n) begin
				rx_byte = {mosi, rx_byte[7:1]};  // lsb first
				bit_n++;
				if (bit_n == 8) begin
					if (rx_byte !== send_byte(byte_n))
						mismatch("pad transaction bytes", send_byte(byte_n), rx_byte, err_mosi);
					byte_n++;
					bit_n = 0;
				end
			end
			if (cs_n && !prev_cs) begin
				if (byte_n != `SPI_BYTES || bit_n != 0) begin
					$display("pad transaction bytes: transaction ended after %0d bytes and %0d bits",
						byte_n, bit_n);
					err_mosi++;
					errors++;
				end
				if (pad_buttons !== exp_btns[poll*16 +: 16])
					mismatch("pad buttons", exp_btns[poll*16 +: 16], pad_buttons, err_btn);
				poll++;
				byte_n = 0;
				bit_n = 0;
				if (poll == 2) begin
					finish_test("pad transaction bytes", err_mosi);
					finish_test("pad buttons", err_btn);
				end
			end
			if (!done && scan_done && poll >= 2) begin
				$display("tests passed %0d, failed %0d, errors %0d", n_pass, n_fail, errors);
				done = 1'b1;
			end
		end
		prev_latch = latch;
		prev_oe = display_oe;
		prev_spi = spi_clk;
		prev_cs = cs_n;
		prev_row = row_addr;
	end

endmodule

`default_nettype wire

/* verification/led_panel_sva.sv */
// --------------------------------------------------
// Scan and serial protocol assertions
// --------------------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "led_panel_consts.svh"

module led_panel_sva (
	input wire clk,
	input wire rst,
	input wire latch,
	input wire display_oe,
	input wire spi_clk,
	input wire cs_n,
	input wire mosi
);

	// latch while the panel is lit would smear rows
	a_latch_oe: assert property (@(posedge clk) disable iff (rst)
		!(latch && !display_oe))
		else $error("latch and output enable active together");

	a_latch_len: assert property (@(posedge clk) disable iff (rst)
		$fell(latch) |-> ($past(latch, `LATCH_CYCLES) && !$past(latch, `LATCH_CYCLES + 1)))
		else $error("latch pulse length wrong");

	a_mosi_stable: assert property (@(posedge clk) disable iff (rst)
		(spi_clk && !cs_n) |=> (!spi_clk || cs_n || $stable(mosi)))
		else $error("mosi changed while spi_clk high");

endmodule

`default_nettype wire

/* hdl/led_panel_top.sv */
// --------------------------------------------------
// LED panel top level
// --------------------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "led_panel_consts.svh"

module led_panel_top
	import led_panel_pkg::*;
(
	input  wire              clk,
	input  wire              rst,
	input  wire pix_write_t  pix_wr,
	output row_t             row_addr,
	output col_t             col_addr,
	output logic             display_clk,
	output logic             latch,
	output logic             display_oe,
	output color_t           dout_a,
	output color_t           dout_b,
	output logic             spi_clk,
	output logic             cs_n,
	output logic             mosi,
	input  wire              miso,
	output logic [15:0]      pad_buttons
);

	logic        rd_en;
	scan_pos_t   scan_pos;
	pixel_pair_t pixels;

	frame_memory u_fmem (
		.clk      (clk),
		.rst      (rst),
		.pix_wr   (pix_wr),
		.rd_en    (rd_en),
		.scan_pos (scan_pos),
		.pixels   (pixels)
	);

	row_scanner u_scan (
		.clk         (clk),
		.rst         (rst),
		.rd_en       (rd_en),
		.scan_pos    (scan_pos),
		.row_addr    (row_addr),
		.col_addr    (col_addr),
		.display_clk (display_clk),
		.latch       (latch),
		.display_oe  (display_oe)
	);

	pad_poller u_pad (
		.clk         (clk),
		.rst         (rst),
		.spi_clk     (spi_clk),
		.cs_n        (cs_n),
		.mosi        (mosi),
		.miso        (miso),
		.pad_buttons (pad_buttons)
	);

	assign dout_a = pixels.top;     // rows 0 to 31
	assign dout_b = pixels.bottom;  // rows 32 to 63

endmodule

`default_nettype wire

/* hdl/pad_poller.sv */
// --------------------------------------------------
// Game pad serial poller
// --------------------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "led_panel_consts.svh"

module pad_poller
	import led_panel_pkg::*;
(
	input  wire         clk,
	input  wire         rst,
	output logic        spi_clk,
	output logic        cs_n,
	output logic        mosi,
	input  wire         miso,
	output logic [15:0] pad_buttons
);

	localparam int idle_w = $clog2(`SPI_IDLE_CYCLES);
	localparam int half_w = $clog2(`SPI_HALF_CYCLES);
	localparam int gap_w = $clog2(`SPI_BYTE_GAP);

	// byte 0 in the low bits, sent lsb first
	localparam logic [8*`SPI_BYTES-1:0] send_msg = 40'h00_0000_4201;

	spi_state_t        state;
	logic [idle_w-1:0] idle_cnt;
	logic [half_w-1:0] half_cnt;
	logic [gap_w-1:0]  gap_cnt;
	logic [2:0]        bit_cnt;
	logic [2:0]        byte_cnt;
	logic [7:0]        rx_shift;
	logic [7:0]        rx_b3;
	logic              half_done;
	logic              sample_now;
	logic              last_byte;

	assign half_done = (half_cnt == half_w'(`SPI_HALF_CYCLES - 1));
	assign sample_now = (state == BIT_HI) && (half_cnt == half_w'(`SPI_HALF_CYCLES - 2));
	assign last_byte = (byte_cnt == 3'(`SPI_BYTES - 1));

	// receive side, lsb first
	always_ff @(posedge clk) begin
		if (sample_now)
			rx_shift <= {miso, rx_shift[7:1]};
		if (state == BIT_HI && half_done && bit_cnt == 3'd7 && byte_cnt == 3'd3)
			rx_b3 <= rx_shift;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= IDLE;
			cs_n <= 1'b1;
			spi_clk <= 1'b1;
			mosi <= 1'b0;
			idle_cnt <= '0;
			half_cnt <= '0;
			gap_cnt <= '0;
			bit_cnt <= '0;
			byte_cnt <= '0;
			pad_buttons <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (idle_cnt == idle_w'(`SPI_IDLE_CYCLES - 1)) begin
						idle_cnt <= '0;
						cs_n <= 1'b0;
						spi_clk <= 1'b0;
						mosi <= send_msg[0];
						state <= BIT_LO;
					end else begin
						idle_cnt <= idle_cnt + 1'b1;
					end
				end
				BIT_LO: begin
					half_cnt <= half_done ? '0 : half_cnt + 1'b1;
					if (half_done) begin
						spi_clk <= 1'b1;
						state <= BIT_HI;
					end
				end
				BIT_HI: begin
					half_cnt <= half_done ? '0 : half_cnt + 1'b1;
					if (half_done && bit_cnt == 3'd7) begin
						bit_cnt <= '0;
						state <= BYTE_GAP;  // clock parked high, mosi held
					end else if (half_done) begin
						bit_cnt <= bit_cnt + 3'd1;
						spi_clk <= 1'b0;
						mosi <= send_msg[{byte_cnt, bit_cnt + 3'd1}];
						state <= BIT_LO;
					end
				end
				BYTE_GAP: begin
					if (gap_cnt == gap_w'(`SPI_BYTE_GAP - 1)) begin
						gap_cnt <= '0;
						if (last_byte) begin
							byte_cnt <= '0;
							cs_n <= 1'b1;
							mosi <= 1'b0;
							pad_buttons <= {rx_shift, rx_b3};  // byte 4 still in shifter
							state <= IDLE;
						end else begin
							byte_cnt <= byte_cnt + 3'd1;
							spi_clk <= 1'b0;
							mosi <= send_msg[{byte_cnt + 3'd1, 3'd0}];
							state <= BIT_LO;
						end
					end else begin
						gap_cnt <= gap_cnt + 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/row_scanner.sv */
// --------------------------------------------------
// HUB75 row scanner
// --------------------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "led_panel_consts.svh"

module row_scanner
	import led_panel_pkg::*;
(
	input  wire        clk,
	input  wire        rst,
	output logic       rd_en,
	output scan_pos_t  scan_pos,
	output row_t       row_addr,
	output col_t       col_addr,
	output logic       display_clk,
	output logic       latch,
	output logic       display_oe
);

	scan_state_t state;
	scan_state_t state_n;
	logic [3:0]  phase_cnt;  // latch, display and gap lengths
	logic        row_done;

	always_comb begin
		state_n = state;
		case (state)
			FETCH:    state_n = DATAWAIT;
			DATAWAIT: state_n = SHIFT_HI;  // memory has two cycles latency
			SHIFT_HI: state_n = SHIFT_LO;
			SHIFT_LO: begin
				if (col_addr == col_t'(`PANEL_COLS - 1))
					state_n = LATCH;
				else
					state_n = FETCH;
			end
			LATCH: begin
				if (phase_cnt == 4'(`LATCH_CYCLES - 1))
					state_n = DISPLAY;
			end
			DISPLAY: begin
				if (phase_cnt == 4'(`OE_CYCLES - 1))
					state_n = ROW_GAP;
			end
			ROW_GAP: begin
				if (phase_cnt == 4'(`ROW_GAP_CYCLES - 1))
					state_n = FETCH;
			end
			default: state_n = FETCH;
		endcase
	end

	assign row_done = (state == ROW_GAP) && (state_n == FETCH);

	// read request goes out during FETCH
	assign rd_en = (state == FETCH);
	assign scan_pos = {row_addr, col_addr};

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= FETCH;
			phase_cnt <= '0;
		end else begin
			state <= state_n;
			if (state_n != state)
				phase_cnt <= '0;
			else
				phase_cnt <= phase_cnt + 4'd1;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			col_addr <= '0;
			row_addr <= '0;
		end else begin
			if (state == SHIFT_LO)
				col_addr <= col_addr + 1'b1;  // 63 wraps to 0
			if (row_done) begin
				if (row_addr == row_t'(`SCAN_ROWS - 1))
					row_addr <= '0;
				else
					row_addr <= row_addr + 1'b1;
			end
		end
	end

	// panel pins follow the next state so they line up with state
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			display_clk <= 1'b0;
			latch <= 1'b0;
			display_oe <= 1'b1;
		end else begin
			display_clk <= (state_n == SHIFT_HI);
			latch <= (state_n == LATCH);
			display_oe <= (state_n != DISPLAY);  // active low
		end
	end

endmodule

`default_nettype wire

/* hdl/frame_memory.sv */
// --------------------------------------------------
// Pixel frame memory
// --------------------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "led_panel_consts.svh"

module frame_memory
	import led_panel_pkg::*;
(
	input  wire              clk,
	input  wire              rst,
	input  wire pix_write_t  pix_wr,
	input  wire              rd_en,
	input  wire scan_pos_t   scan_pos,
	output pixel_pair_t      pixels
);

	localparam int depth = `PANEL_ROWS * `PANEL_COLS;

	color_t mem [depth];
	color_t top_q;
	color_t bot_q;
	logic [11:0] top_addr;
	logic [11:0] bot_addr;

	initial begin
		for (int i = 0; i < depth; i++)
			mem[i] = '0;  // blank panel at power up
	end

	// bottom half of the panel lives at row + 32
	assign top_addr = {1'b0, scan_pos.row, scan_pos.col};
	assign bot_addr = {1'b1, scan_pos.row, scan_pos.col};

	always_ff @(posedge clk) begin
		if (pix_wr.valid)
			mem[{pix_wr.y, pix_wr.x}] <= pix_wr.color;
	end

	// first read stage
	always_ff @(posedge clk) begin
		if (rd_en) begin
			top_q <= mem[top_addr];
			bot_q <= mem[bot_addr];
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			pixels <= '0;
		else
			pixels <= {top_q, bot_q};  // second stage
	end

endmodule

`default_nettype wire

/* hdl/led_panel_pkg.sv */
// --------------------------------------------------
// LED panel types
// --------------------------------------------------
`default_nettype none
`include "led_panel_consts.svh"

package led_panel_pkg;

	typedef logic [5:0] col_t;
	typedef logic [4:0] row_t;
	typedef logic [`COLOR_W-1:0] color_t;

	// one host pixel write
	typedef struct packed {
		logic       valid;
		logic [5:0] y;
		logic [5:0] x;
		color_t     color;
	} pix_write_t;

	typedef struct packed {
		row_t row;
		col_t col;
	} scan_pos_t;

	typedef struct packed {
		color_t top;
		color_t bottom;  // row + 32
	} pixel_pair_t;

	typedef enum logic [2:0] {
		FETCH, DATAWAIT, SHIFT_HI, SHIFT_LO, LATCH, DISPLAY, ROW_GAP
	} scan_state_t;

	typedef enum logic [1:0] {IDLE, BIT_LO, BIT_HI, BYTE_GAP} spi_state_t;

endpackage

`default_nettype wire

/* hdl/led_panel_consts.svh */
// --------------------------------------------------
// LED panel and pad constants
// --------------------------------------------------
`ifndef LED_PANEL_CONSTS_SVH
`define LED_PANEL_CONSTS_SVH

// panel geometry
`define PANEL_COLS 64
`define PANEL_ROWS 64
`define SCAN_ROWS 32  // two rows driven at once
`define COLOR_W 4

// scan phases after the last column, in clocks
`define LATCH_CYCLES 4
`define OE_CYCLES 8
`define ROW_GAP_CYCLES 6

// pad serial link, in clocks
`define SPI_HALF_CYCLES 101
`define SPI_BYTE_GAP 1001
`define SPI_IDLE_CYCLES 5001
`define SPI_BYTES 5  // 0x01 0x42 then three reads

`endif
